/* hdl/fetch_addr_sel.sv */
/*
  Next fetch address selection. Purely combinational.
  The interrupt offset must fit below FETCH_VEC_ALIGN, so ids above 31 are not supported.
*/

`default_nettype none
`timescale 1ns/10ps

`include "fetch_config.svh"

module fetch_addr_sel import fetch_pkg::*; (
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  logic [4:0]  irq_id_i,
  input  fetch_addr_t boot_addr_i,
  input  fetch_addr_t branch_target_i,
  input  fetch_addr_t csr_mepc_i,
  input  fetch_addr_t csr_depc_i,
  input  fetch_addr_t csr_mtvec_i,
  output fetch_addr_t fetch_addr_n_o
);

  localparam int unsigned AW = `FETCH_AW;
  localparam int unsigned VA = `FETCH_VEC_ALIGN;

  fetch_addr_t trap_base;
  fetch_addr_t irq_offset;
  fetch_addr_t exc_pc;
  fetch_addr_t addr_mux;

  // mtvec with the mode bits and low bits cleared
  assign trap_base  = {csr_mtvec_i[AW-1:VA], {VA{1'b0}}};
  // one word per interrupt id
  assign irq_offset = {{(AW-7){1'b0}}, irq_id_i, 2'b00};

  // handler address
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = trap_base;
      EXC_PC_IRQ:     exc_pc = trap_base + irq_offset;
      EXC_PC_DBD:     exc_pc = `FETCH_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `FETCH_DM_EXC_ADDR;
      default:        exc_pc = trap_base;
    endcase
  end

  // next pc source
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: addr_mux = {boot_addr_i[AW-1:VA], {VA{1'b0}}};
      PC_JUMP: addr_mux = branch_target_i;
      PC_EXC:  addr_mux = exc_pc;
      PC_ERET: addr_mux = csr_mepc_i;
      PC_DRET: addr_mux = csr_depc_i;
      default: addr_mux = {boot_addr_i[AW-1:VA], {VA{1'b0}}};
    endcase
  end

  // halfword alignment at least, the buffer aligns to words
  assign fetch_addr_n_o = {addr_mux[AW-1:1], 1'b0};

endmodule

`default_nettype wire

/* hdl/fetch_config.svh */
/*
  Build-time constants of the fetch stage. The boot address and the trap base
  must have FETCH_VEC_ALIGN zero low bits. All instructions are 32 bits wide.
*/

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

// address and instruction width
`define FETCH_AW 32

//////////////////////////////////////////////////
// fixed entry addresses
//////////////////////////////////////////////////

// debug module halt entry
`define FETCH_DM_HALT_ADDR 32'h1A11_0800
// debug module exception entry
`define FETCH_DM_EXC_ADDR 32'h1A11_0808

// low bits forced to zero in boot address and trap base
`define FETCH_VEC_ALIGN 8

// prefetch FIFO entries, also the outstanding request limit
`define FETCH_FIFO_DEPTH 2

`endif

/* hdl/fetch_ctrl.sv */
/*
  IF-ID handshake control. A pc set in the accepting cycle squashes the word:
  the registers still load but valid and new stay low.
*/

`default_nettype none
`timescale 1ns/10ps

module fetch_ctrl import fetch_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,

  input  logic    pc_set_i,
  input  pc_sel_e pc_mux_i,
  input  logic    fetch_valid_i,
  input  logic    id_in_ready_i,
  input  logic    instr_valid_clear_i,

  output logic    branch_req_o,
  output logic    fetch_ready_o,
  output logic    if_id_we_o,
  output logic    instr_valid_id_o,
  output logic    instr_new_id_o,
  output logic    csr_mtvec_init_o
);

  logic accept;
  logic valid_d;
  logic valid_q;
  logic new_d;
  logic new_q;

  // every pc set redirects the buffer
  assign branch_req_o  = pc_set_i;
  assign fetch_ready_o = id_in_ready_i;

  // word offered and ID ready
  assign accept     = fetch_valid_i & id_in_ready_i;
  assign if_id_we_o = accept;

  // valid holds until cleared, a new word wins over the clear
  assign valid_d = (accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);
  // one cycle pulse per word that really enters ID
  assign new_d   = accept & ~pc_set_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= new_d;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // CSR file loads mtvec from the boot address
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

/* hdl/fetch_pkg.sv */
/*
  Types shared by the fetch stage modules.
  Encodings of the select enums are local to this stage.
*/

`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

  // one address word
  typedef logic [`FETCH_AW-1:0] fetch_addr_t;

  // one instruction word
  typedef logic [`FETCH_AW-1:0] fetch_instr_t;

  // source of the next fetch address on a pc set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // source of the handler address for PC_EXC
  typedef enum logic [1:0] {
    // synchronous exception, trap base
    EXC_PC_EXC     = 2'd0,
    // vectored interrupt, base plus 4 * id
    EXC_PC_IRQ     = 2'd1,
    // debug halt request
    EXC_PC_DBD     = 2'd2,
    // exception while in debug mode
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

endpackage

`default_nettype wire

/* hdl/if_id_regs.sv */
/*
  IF-ID pipeline registers, frozen unless written. Cleared to zero on reset.
*/

`default_nettype none
`timescale 1ns/10ps

module if_id_regs import fetch_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  input  logic         we_i,
  input  fetch_instr_t instr_i,
  input  fetch_addr_t  pc_i,
  input  logic         err_i,

  output fetch_instr_t instr_rdata_id_o,
  output fetch_addr_t  pc_id_o,
  output logic         instr_fetch_err_o
);

  fetch_instr_t instr_q;
  fetch_addr_t  pc_q;
  logic         err_q;

  // load on every accepted word, squashed ones included
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_q <= '0;
      pc_q    <= '0;
      err_q   <= 1'b0;
    end else if (we_i) begin
      instr_q <= instr_i;
      pc_q    <= pc_i;
      // bus error travels with its word
      err_q   <= err_i;
    end
  end

  assign instr_rdata_id_o  = instr_q;
  assign pc_id_o           = pc_q;
  assign instr_fetch_err_o = err_q;

endmodule

`default_nettype wire

/* hdl/if_stage.sv */
/*
  Instruction fetch stage top. 32-bit word-aligned instructions only.
  Stale responses after a pc set are dropped inside the prefetch buffer.
*/

`default_nettype none
`timescale 1ns/10ps

module if_stage import fetch_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  input  logic         req_i,
  input  fetch_addr_t  boot_addr_i,

  // instruction bus
  output logic         instr_req_o,
  output fetch_addr_t  instr_addr_o,
  input  logic         instr_gnt_i,
  input  logic         instr_rvalid_i,
  input  fetch_instr_t instr_rdata_i,
  input  logic         instr_err_i,

  // pc set from the controller
  input  logic         pc_set_i,
  input  pc_sel_e      pc_mux_i,
  input  exc_pc_sel_e  exc_pc_mux_i,
  input  logic [4:0]   irq_id_i,
  input  fetch_addr_t  branch_target_i,
  input  fetch_addr_t  csr_mepc_i,
  input  fetch_addr_t  csr_depc_i,
  input  fetch_addr_t  csr_mtvec_i,
  output logic         csr_mtvec_init_o,

  // ID side
  input  logic         instr_valid_clear_i,
  input  logic         id_in_ready_i,
  output logic         instr_valid_id_o,
  output logic         instr_new_id_o,
  output fetch_instr_t instr_rdata_id_o,
  output logic         instr_fetch_err_o,
  output fetch_addr_t  pc_if_o,
  output fetch_addr_t  pc_id_o,

  output logic         pc_mismatch_alert_o,
  output logic         if_busy_o
);

  fetch_addr_t  fetch_addr_n;
  logic         branch_req;
  logic         fetch_ready;
  logic         fetch_valid;
  fetch_instr_t fetch_rdata;
  logic         fetch_err;
  logic         if_id_we;

  //////////////////////////////////////////////////
  // address selection and prefetch
  //////////////////////////////////////////////////

  fetch_addr_sel fetch_addr_sel_i (
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .irq_id_i        (irq_id_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_depc_i      (csr_depc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .fetch_addr_n_o  (fetch_addr_n)
  );

  // head address doubles as the IF pc
  prefetch_buffer prefetch_buffer_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (branch_req),
    .ready_i        (fetch_ready),
    .addr_i         (fetch_addr_n),
    .valid_o        (fetch_valid),
    .rdata_o        (fetch_rdata),
    .addr_o         (pc_if_o),
    .err_o          (fetch_err),
    .busy_o         (if_busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  //////////////////////////////////////////////////
  // IF-ID boundary
  //////////////////////////////////////////////////

  fetch_ctrl fetch_ctrl_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .fetch_valid_i       (fetch_valid),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .branch_req_o        (branch_req),
    .fetch_ready_o       (fetch_ready),
    .if_id_we_o          (if_id_we),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .csr_mtvec_init_o    (csr_mtvec_init_o)
  );

  if_id_regs if_id_regs_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .we_i              (if_id_we),
    .instr_i           (fetch_rdata),
    .pc_i              (pc_if_o),
    .err_i             (fetch_err),
    .instr_rdata_id_o  (instr_rdata_id_o),
    .pc_id_o           (pc_id_o),
    .instr_fetch_err_o (instr_fetch_err_o)
  );

  pc_incr_check pc_incr_check_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .new_instr_i  (if_id_we),
    .branch_req_i (branch_req),
    .pc_if_i      (pc_if_o),
    .pc_id_i      (pc_id_o),
    .alert_o      (pc_mismatch_alert_o)
  );

endmodule

`default_nettype wire

/* hdl/pc_incr_check.sv */
/*
  Sequential PC check. Assumes fixed 4-byte instructions.
  The alert is combinational and only armed after a sequential step.
*/

`default_nettype none
`timescale 1ns/10ps

module pc_incr_check import fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        new_instr_i,
  input  logic        branch_req_i,
  input  fetch_addr_t pc_if_i,
  input  fetch_addr_t pc_id_i,

  output logic        alert_o
);

  logic seq_d;
  logic seq_q;

  // armed once a word enters ID, disarmed by any redirect
  assign seq_d = (seq_q | new_instr_i) & ~branch_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  // offered pc must follow the one in ID
  assign alert_o = seq_q & (pc_if_i != (pc_id_i + fetch_addr_t'(4)));

endmodule

`default_nettype wire

/* hdl/prefetch_buffer.sv */
/*
  Instruction bus master with a small word FIFO. Responses must come back in order.
  A request waiting for its grant keeps its address, even across a branch.
  Requests stop when outstanding plus stored words reach FETCH_FIFO_DEPTH.
*/

`default_nettype none
`timescale 1ns/10ps

`include "fetch_config.svh"

module prefetch_buffer import fetch_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  input  logic         req_i,
  input  logic         branch_i,
  input  logic         ready_i,
  input  fetch_addr_t  addr_i,

  output logic         valid_o,
  output fetch_instr_t rdata_o,
  output fetch_addr_t  addr_o,
  output logic         err_o,
  output logic         busy_o,

  output logic         instr_req_o,
  output fetch_addr_t  instr_addr_o,
  input  logic         instr_gnt_i,
  input  logic         instr_rvalid_i,
  input  fetch_instr_t instr_rdata_i,
  input  logic         instr_err_i
);

  localparam int unsigned AW    = `FETCH_AW;
  localparam int unsigned DEPTH = `FETCH_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // request tracking
  logic             valid_new_req;
  logic             valid_req;
  logic             valid_req_q;
  logic             new_issue;
  logic             req_granted;
  logic             discard_req_d;
  logic             discard_req_q;
  fetch_addr_t      branch_addr;
  fetch_addr_t      fetch_addr_d;
  fetch_addr_t      fetch_addr_q;
  fetch_addr_t      stored_addr_q;
  logic [DEPTH-1:0] new_slot;
  logic [DEPTH-1:0] outstanding_n;
  logic [DEPTH-1:0] outstanding_s;
  logic [DEPTH-1:0] outstanding_q;
  logic [DEPTH-1:0] discard_n;
  logic [DEPTH-1:0] discard_s;
  logic [DEPTH-1:0] discard_q;
  logic [CNT_W-1:0] live_cnt;
  logic             fifo_ready;

  // word FIFO
  fetch_instr_t     mem_rdata_q [DEPTH];
  logic [DEPTH-1:0] mem_err_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push;
  logic             pop;
  fetch_addr_t      out_addr_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  // branches restart on a word boundary
  assign branch_addr = {addr_i[AW-1:2], 2'b00};

  // outstanding responses that will land in the FIFO
  always_comb begin
    live_cnt = '0;
    for (int i = 0; i < DEPTH; i++) begin
      live_cnt = live_cnt + CNT_W'(outstanding_q[i] & ~discard_q[i]);
    end
  end

  // room left for one more word, pops in this cycle not counted
  assign fifo_ready = ({1'b0, cnt_q} + {1'b0, live_cnt}) < (CNT_W + 1)'(DEPTH);

  // a branch flushes the FIFO so only the slot limit applies
  assign valid_new_req = req_i & (fifo_ready | branch_i) & ~outstanding_q[DEPTH-1];
  assign valid_req     = valid_req_q | valid_new_req;
  assign req_granted   = valid_req & instr_gnt_i;
  // fresh request, not the replay of a stalled one
  assign new_issue     = valid_new_req & ~valid_req_q;

  // a stalled request becomes stale when a branch passes it
  assign discard_req_d = valid_req_q & (branch_i | discard_req_q);

  assign instr_req_o  = valid_req;
  assign instr_addr_o = valid_req_q ? stored_addr_q : (branch_i ? branch_addr : fetch_addr_q);

  // fetch pointer moves on issue, the stored copy covers the wait for grant
  always_comb begin
    fetch_addr_d = branch_i ? branch_addr : fetch_addr_q;
    if (new_issue) begin
      fetch_addr_d = fetch_addr_d + AW'(4);
    end
  end

  // thermometer of request slots, slot 0 is the oldest
  assign new_slot      = ((outstanding_q << 1) | DEPTH'(1)) & ~outstanding_q;
  assign outstanding_n = outstanding_q | ({DEPTH{req_granted}} & new_slot);
  assign discard_n     = discard_q
                       | ({DEPTH{branch_i}} & outstanding_q)
                       | ({DEPTH{req_granted & discard_req_d}} & new_slot);

  // each response retires the oldest slot
  assign outstanding_s = instr_rvalid_i ? (outstanding_n >> 1) : outstanding_n;
  assign discard_s     = instr_rvalid_i ? (discard_n >> 1) : discard_n;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_req_q   <= 1'b0;
      discard_req_q <= 1'b0;
      outstanding_q <= '0;
      discard_q     <= '0;
      fetch_addr_q  <= '0;
    end else begin
      valid_req_q   <= valid_req & ~instr_gnt_i;
      discard_req_q <= discard_req_d;
      outstanding_q <= outstanding_s;
      discard_q     <= discard_s;
      fetch_addr_q  <= fetch_addr_d;
    end
  end

  // address held while the bus withholds the grant
  always_ff @(posedge clk_i) begin
    if (new_issue && !instr_gnt_i) begin
      stored_addr_q <= instr_addr_o;
    end
  end

  //////////////////////////////////////////////////
  // word FIFO
  //////////////////////////////////////////////////

  // stale responses and anything arriving with a branch are dropped
  assign push = instr_rvalid_i & ~discard_q[0] & ~branch_i;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
      out_addr_q <= '0;
    end else if (branch_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
      out_addr_q <= branch_addr;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q   <= ptr_inc(rd_ptr_q);
        // next word in the sequence
        out_addr_q <= out_addr_q + AW'(4);
      end
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_rdata_q[wr_ptr_q] <= instr_rdata_i;
      mem_err_q[wr_ptr_q]   <= instr_err_i;
    end
  end

  assign valid_o = (cnt_q != '0);
  assign rdata_o = mem_rdata_q[rd_ptr_q];
  assign err_o   = mem_err_q[rd_ptr_q];
  assign addr_o  = out_addr_q;

  // busy while anything is on the bus
  assign busy_o = (|outstanding_q) | instr_req_o;

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_addr_sel.sv
hdl/prefetch_buffer.sv
hdl/fetch_ctrl.sv
hdl/if_id_regs.sv
hdl/pc_incr_check.sv
hdl/if_stage.sv
sim/if_stage_checker.sv
sim/tb_if_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f project.f \
  --top-module tb_if_stage \
  -o Vtb_if_stage

./obj_dir/Vtb_if_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
  exit 0
fi
exit 1

/* sim/if_stage_checker.sv */
/*
  Watches the fetch stage ports and compares them with a reference model.
  Sampling is on the falling clock edge, where inputs and outputs are stable.
  Also serves the memory word and error window to the bus model.
*/

`default_nettype none
`timescale 1ns/10ps

`include "fetch_config.svh"

module if_stage_checker import fetch_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         pc_set_i,
  input  pc_sel_e      pc_mux_i,
  input  exc_pc_sel_e  exc_pc_mux_i,
  input  logic [4:0]   irq_id_i,
  input  fetch_addr_t  boot_addr_i,
  input  fetch_addr_t  branch_target_i,
  input  fetch_addr_t  csr_mepc_i,
  input  fetch_addr_t  csr_depc_i,
  input  fetch_addr_t  csr_mtvec_i,
  input  logic         id_in_ready_i,
  input  logic         instr_valid_clear_i,
  input  logic         instr_valid_id_o,
  input  logic         instr_new_id_o,
  input  fetch_instr_t instr_rdata_id_o,
  input  logic         instr_fetch_err_o,
  input  fetch_addr_t  pc_id_o,
  input  logic         csr_mtvec_init_o,
  input  logic         pc_mismatch_alert_o,
  input  logic         instr_req_o,
  input  fetch_addr_t  instr_addr_o,
  input  logic         instr_gnt_i,
  input  logic         instr_rvalid_i,
  input  fetch_addr_t  pc_if_o,
  input  logic         if_busy_o,
  input  fetch_addr_t  resp_addr_i,
  output fetch_instr_t resp_word_o,
  output logic         resp_err_o,
  output int           err_cnt_o,
  output int           word_cnt_o
);

  fetch_addr_t exp_pc;
  logic        have_target;
  logic        prev_valid;
  logic        prev_clear;
  logic        prev_ready;
  logic        prev_set;
  // bus state of the previous cycle
  logic        prev_req;
  logic        prev_gnt;
  fetch_addr_t prev_addr;
  // granted requests still waiting for their response
  int          outst;

  // fill pattern, a mix of every address bit
  function automatic fetch_instr_t mem_word(input fetch_addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  // bus error window, one 256-byte page around the trap base
  function automatic logic in_err_window(input fetch_addr_t a);
    return (a >= 32'h0000_2000) && (a < 32'h0000_2100);
  endfunction

  // target rule of a pc set, word aligned as the buffer fetches it
  function automatic fetch_addr_t pc_target();
    fetch_addr_t base;
    fetch_addr_t t;
    base = csr_mtvec_i & ({32{1'b1}} << `FETCH_VEC_ALIGN);
    case (pc_mux_i)
      PC_BOOT: t = boot_addr_i & ({32{1'b1}} << `FETCH_VEC_ALIGN);
      PC_JUMP: t = branch_target_i;
      PC_ERET: t = csr_mepc_i;
      PC_DRET: t = csr_depc_i;
      default: begin
        case (exc_pc_mux_i)
          EXC_PC_IRQ:     t = base + {25'd0, irq_id_i, 2'b00};
          EXC_PC_DBD:     t = `FETCH_DM_HALT_ADDR;
          EXC_PC_DBG_EXC: t = `FETCH_DM_EXC_ADDR;
          default:        t = base;
        endcase
      end
    endcase
    return t & 32'hFFFF_FFFC;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("** Error %s: expected %h, actual %h at %0t", name, exp_v, act_v, $time);
    err_cnt_o = err_cnt_o + 1;
  endtask

  assign resp_word_o = mem_word(resp_addr_i);
  assign resp_err_o  = in_err_window(resp_addr_i);

  initial begin
    err_cnt_o   = 0;
    word_cnt_o  = 0;
    exp_pc      = '0;
    have_target = 1'b0;
    prev_valid  = 1'b0;
    prev_clear  = 1'b0;
    prev_ready  = 1'b0;
    prev_set    = 1'b0;
    prev_req    = 1'b0;
    prev_gnt    = 1'b0;
    prev_addr   = '0;
    outst       = 0;
  end

  always @(negedge clk_i) begin
    if (rst_ni) begin
      // valid follows new word or holds until cleared
      if (instr_valid_id_o !== (instr_new_id_o | (prev_valid & ~prev_clear))) begin
        report_mismatch("valid_id", {31'd0, instr_new_id_o | (prev_valid & ~prev_clear)},
                        {31'd0, instr_valid_id_o});
      end
      if (instr_new_id_o && (prev_set || !prev_ready)) begin
        $display("** Error new_id: pulse after a squash or without ID ready at %0t", $time);
        err_cnt_o = err_cnt_o + 1;
      end
      if (instr_new_id_o) begin
        if (!have_target) begin
          $display("** Error new_id: instruction arrived before any pc set at %0t", $time);
          err_cnt_o = err_cnt_o + 1;
        end
        if (pc_id_o !== exp_pc) begin
          report_mismatch("pc_id", exp_pc, pc_id_o);
        end
        if (instr_rdata_id_o !== mem_word(exp_pc)) begin
          report_mismatch("rdata_id", mem_word(exp_pc), instr_rdata_id_o);
        end
        if (instr_fetch_err_o !== in_err_window(exp_pc)) begin
          report_mismatch("fetch_err", {31'd0, in_err_window(exp_pc)},
                          {31'd0, instr_fetch_err_o});
        end
        // next offered pc is the word after the one entering ID
        if (pc_if_o !== exp_pc + 32'd4) begin
          report_mismatch("pc_if", exp_pc + 32'd4, pc_if_o);
        end
        exp_pc     = exp_pc + 32'd4;
        word_cnt_o = word_cnt_o + 1;
      end
      if (csr_mtvec_init_o !== (pc_set_i && pc_mux_i == PC_BOOT)) begin
        report_mismatch("mtvec_init", {31'd0, pc_set_i && pc_mux_i == PC_BOOT},
                        {31'd0, csr_mtvec_init_o});
      end
      if (pc_mismatch_alert_o !== 1'b0) begin
        report_mismatch("pc_alert", 32'd0, {31'd0, pc_mismatch_alert_o});
      end
      // busy while a request is on the bus or a response is owed
      if (if_busy_o !== ((outst != 0) || instr_req_o)) begin
        report_mismatch("busy", {31'd0, (outst != 0) || instr_req_o}, {31'd0, if_busy_o});
      end
      // a request waiting for its grant keeps its address
      if (prev_req && !prev_gnt) begin
        if (instr_req_o !== 1'b1) begin
          $display("** Error bus_hold: request withdrawn before its grant at %0t", $time);
          err_cnt_o = err_cnt_o + 1;
        end else if (instr_addr_o !== prev_addr) begin
          report_mismatch("bus_hold", prev_addr, instr_addr_o);
        end
      end else if (pc_set_i && outst == 0) begin
        // idle bus, the redirect target goes out in the same cycle
        if (instr_req_o !== 1'b1) begin
          $display("** Error set_req: no request in the cycle of a pc set at %0t", $time);
          err_cnt_o = err_cnt_o + 1;
        end else if (instr_addr_o !== pc_target()) begin
          report_mismatch("set_addr", pc_target(), instr_addr_o);
        end
      end
      // redirect takes effect at the coming edge
      if (pc_set_i) begin
        exp_pc      = pc_target();
        have_target = 1'b1;
      end
      outst      = outst + ((instr_req_o && instr_gnt_i) ? 1 : 0) - (instr_rvalid_i ? 1 : 0);
      prev_valid = instr_valid_id_o;
      prev_clear = instr_valid_clear_i;
      prev_ready = id_in_ready_i;
      prev_set   = pc_set_i;
      prev_req   = instr_req_o;
      prev_gnt   = instr_gnt_i;
      prev_addr  = instr_addr_o;
    end else begin
      // control outputs low while reset is held
      if ({instr_req_o, instr_valid_id_o, instr_new_id_o, csr_mtvec_init_o,
           pc_mismatch_alert_o, if_busy_o} !== 6'd0) begin
        report_mismatch("reset_low", 32'd0,
                        {26'd0, instr_req_o, instr_valid_id_o, instr_new_id_o,
                         csr_mtvec_init_o, pc_mismatch_alert_o, if_busy_o});
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_if_stage.sv */
/*
  Random testbench of the fetch stage with an in-order instruction memory model.
  All stimulus comes from one LFSR, so every run is the same.
*/

`default_nettype none
`timescale 1ns/10ps

module tb_if_stage import fetch_pkg::*; ();

  localparam int N_CYCLES  = 4000;
  localparam int MAX_DELAY = 4;

  logic clk_i, rst_ni, req_i, pc_set_i, id_in_ready_i, instr_valid_clear_i;
  logic instr_gnt_i, instr_rvalid_i;
  pc_sel_e pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  logic [4:0] irq_id_i;
  fetch_addr_t boot_addr_i, branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  logic instr_req_o, csr_mtvec_init_o, instr_valid_id_o, instr_new_id_o;
  logic instr_fetch_err_o, pc_mismatch_alert_o, if_busy_o;
  fetch_addr_t instr_addr_o, pc_if_o, pc_id_o, resp_addr;
  fetch_instr_t instr_rdata_i, instr_rdata_id_o, resp_word;
  logic instr_err_i, resp_err;
  int err_cnt, word_cnt;
  logic [15:0] lfsr;
  // granted addresses waiting for their response
  fetch_addr_t pend_q[$];

  assign instr_rdata_i = resp_word;
  assign instr_err_i   = resp_err;

  if_stage if_stage_i (.*);

  if_stage_checker if_stage_checker_i (
    .resp_addr_i (resp_addr), .resp_word_o (resp_word), .resp_err_o (resp_err),
    .err_cnt_o (err_cnt), .word_cnt_o (word_cnt), .*
  );

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // bus events of the cycle, seen where everything is settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (instr_rvalid_i) begin
        void'(pend_q.pop_front());
      end
      if (instr_req_o && instr_gnt_i) begin
        pend_q.push_back(instr_addr_o);
      end
    end
  end

  task automatic drive_cycle(input logic boot);
    logic [31:0] v;
    // memory side, random grant and response delays
    rand_bits(1, v);
    instr_gnt_i = v[0];
    rand_bits(1, v);
    instr_rvalid_i = (pend_q.size() > 0) && v[0];
    resp_addr = (pend_q.size() > 0) ? pend_q[0] : '0;
    // core side
    rand_bits(2, v);
    id_in_ready_i = (v[1:0] != 2'd0);
    rand_bits(3, v);
    instr_valid_clear_i = (v[2:0] == 3'd0);
    rand_bits(4, v);
    pc_set_i = boot || (v[3:0] == 4'd0);
    rand_bits(3, v);
    pc_mux_i = boot ? PC_BOOT : pc_sel_e'(v[2:0] % 5);
    rand_bits(2, v);
    exc_pc_mux_i = exc_pc_sel_e'(v[1:0]);
    rand_bits(5, v);
    irq_id_i = v[4:0];
    rand_bits(12, v);
    branch_target_i = {18'd0, v[11:0], 2'b00};
    rand_bits(12, v);
    csr_mepc_i = {18'd0, v[11:0], 2'b00};
    rand_bits(12, v);
    csr_depc_i = {18'd0, v[11:0], 2'b00};
  endtask

  // watchdog sized for every cycle at the longest bus delay
  initial begin
    #((N_CYCLES + 20) * MAX_DELAY * 8);
    $display("watchdog expired, simulation did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    lfsr = 16'd81;
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    irq_id_i = '0;
    id_in_ready_i = 1'b0;
    instr_valid_clear_i = 1'b0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    resp_addr = '0;
    boot_addr_i = 32'h0000_1080;
    branch_target_i = '0;
    csr_mepc_i = '0;
    csr_depc_i = '0;
    // trap base 0x2000 in the error window, vectored mode
    csr_mtvec_i = 32'h0000_2001;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(posedge clk_i);
    #1 req_i = 1'b1;
    drive_cycle(1'b1);
    for (int c = 0; c < N_CYCLES; c++) begin
      @(posedge clk_i);
      #1 drive_cycle(1'b0);
    end
    @(posedge clk_i);
    if (word_cnt == 0) begin
      $display("no instruction ever reached the ID stage");
    end
    $display("words checked %0d, errors %0d", word_cnt, err_cnt);
    if (err_cnt == 0 && word_cnt > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
